//--- hdl/pipe_macros.svh
`ifndef PIPE_MACROS_SVH
`define PIPE_MACROS_SVH

// ########################################
// Pipeline sizing
// ########################################

`define PIPE_NREGS      32      // Architectural registers
`define PIPE_REG_BITS   5       // Register index width
`define PIPE_DATA_BITS  32      // Data word width
`define PIPE_IMM_BITS   16      // Raw immediate width from the op

// Data memory, word addressed
`define PIPE_MEM_WORDS  64      // Depth in words, index taken modulo this

`endif

//--- hdl/pipe_pkg.sv
`include "pipe_macros.svh"

package pipe_pkg;

        typedef logic [`PIPE_REG_BITS-1:0]  reg_idx_t;    // Register index
        typedef logic [`PIPE_DATA_BITS-1:0] word_t;       // Data word
        typedef logic [`PIPE_IMM_BITS-1:0]  imm_t;        // Raw immediate

        typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR} alu_op_t;

        // Operand select, same codes as the classic forwarding block
        typedef enum logic [1:0] {FWD_REG = 2'b00, FWD_MEM = 2'b01, FWD_WB = 2'b10} fwd_sel_t;

        // Store data select
        typedef enum logic [1:0] {ST_MEM = 2'b00, ST_WB = 2'b01, ST_NORMAL = 2'b10} store_sel_t;

        // ########################################
        // Stage contents
        // ########################################

        typedef struct packed {
                logic     valid;
                alu_op_t  alu_op;
                logic     use_imm;        // B comes from the immediate
                logic     mem_read;       // lw
                logic     mem_write;      // sw
                reg_idx_t rd;
                reg_idx_t rs;
                reg_idx_t rt;
                imm_t     imm;
        } op_t;

        typedef struct packed {
                logic     valid;
                alu_op_t  alu_op;
                logic     use_imm;
                logic     mem_read;
                logic     mem_write;
                logic     write_reg;      // Result goes to a nonzero rd
                reg_idx_t rd;
                reg_idx_t rs;
                reg_idx_t rt;
                word_t    rs_val;
                word_t    rt_val;
                word_t    imm;            // Sign extended
        } id_ex_t;

        typedef struct packed {
                logic     valid;
                logic     mem_read;
                logic     mem_write;
                logic     write_reg;
                reg_idx_t rd;
                word_t    alu_result;     // Also the memory address
                word_t    store_data;
        } ex_mem_t;

        typedef struct packed {
                logic     valid;
                logic     write_reg;
                reg_idx_t rd;
                word_t    wb_data;
        } mem_wb_t;

endpackage

//--- hdl/register_file.sv
`include "pipe_macros.svh"

module register_file import pipe_pkg::*; (
        input  logic     i_clk,
        input  logic     i_reset,
        input  reg_idx_t i_rs,          // Read port A
        input  reg_idx_t i_rt,          // Read port B
        input  logic     i_we,          // Write back strobe
        input  reg_idx_t i_wd_rd,
        input  word_t    i_wd,
        output word_t    o_rs_val,
        output word_t    o_rt_val
);

        word_t regs_q [`PIPE_NREGS];

        // Write port, register 0 stays zero
        always_ff @(posedge i_clk) begin
                if (i_reset) begin
                        for (int i = 0; i < `PIPE_NREGS; i++) begin
                                regs_q[i] <= '0;
                        end
                end else if (i_we && (i_wd_rd != '0)) begin
                        regs_q[i_wd_rd] <= i_wd;
                end
        end

        // Reads see a write of the same cycle
        always_comb begin
                o_rs_val = regs_q[i_rs];
                o_rt_val = regs_q[i_rt];
                if (i_we && (i_wd_rd != '0) && (i_wd_rd == i_rs)) begin
                        o_rs_val = i_wd;                // Bypass A
                end
                if (i_we && (i_wd_rd != '0) && (i_wd_rd == i_rt)) begin
                        o_rt_val = i_wd;                // Bypass B
                end
        end

endmodule

//--- hdl/forwarding_unit.sv
module forwarding_unit import pipe_pkg::*; (
        input  reg_idx_t   i_ex_mem_rd,         // Destination held in EX/MEM
        input  reg_idx_t   i_mem_wb_rd,         // Destination held in MEM/WB
        input  reg_idx_t   i_rs,                // Source of operand A
        input  reg_idx_t   i_rt,                // Source of operand B
        input  logic       i_ex_mem_write,      // Op in execute is a store
        input  logic       i_mem_write_reg,     // EX/MEM entry writes a register
        input  logic       i_wb_write_reg,      // MEM/WB entry writes a register
        output fwd_sel_t   o_forwarding_a,
        output fwd_sel_t   o_forwarding_b,
        output store_sel_t o_forwarding_store
);

        logic match_mem_a;
        logic match_wb_a;
        logic match_mem_b;
        logic match_wb_b;

        assign match_mem_a = i_mem_write_reg && (i_ex_mem_rd == i_rs);
        assign match_wb_a  = i_wb_write_reg && (i_mem_wb_rd == i_rs);
        assign match_mem_b = i_mem_write_reg && (i_ex_mem_rd == i_rt);
        assign match_wb_b  = i_wb_write_reg && (i_mem_wb_rd == i_rt);

        // ########################################
        // Operand A
        // ########################################
        always_comb begin
                if (match_mem_a) begin
                        o_forwarding_a = FWD_MEM;       // Nearest writer wins
                end else if (match_wb_a) begin
                        o_forwarding_a = FWD_WB;
                end else begin
                        o_forwarding_a = FWD_REG;
                end
        end

        // ########################################
        // Operand B and store data
        // ########################################
        // A store uses B for the immediate, so rt goes through the store mux
        always_comb begin
                o_forwarding_b     = FWD_REG;
                o_forwarding_store = ST_NORMAL;
                if (match_mem_b) begin
                        if (i_ex_mem_write) begin
                                o_forwarding_store = ST_MEM;    // Store data from EX/MEM
                        end else begin
                                o_forwarding_b = FWD_MEM;
                        end
                end else if (match_wb_b) begin
                        if (i_ex_mem_write) begin
                                o_forwarding_store = ST_WB;     // Store data from MEM/WB
                        end else begin
                                o_forwarding_b = FWD_WB;
                        end
                end
        end

endmodule

//--- hdl/decode_stage.sv
`include "pipe_macros.svh"

module decode_stage import pipe_pkg::*; (
        input  logic    i_clk,
        input  logic    i_reset,
        input  logic    i_op_valid,     // Strobe, low means bubble
        input  op_t     i_op,
        input  mem_wb_t i_wb,           // Write back from MEM/WB
        output id_ex_t  o_id_ex
);

        word_t  rs_val;
        word_t  rt_val;
        logic   op_live;
        id_ex_t id_ex_d;
        id_ex_t id_ex_q;

        register_file u_regs (
                .i_clk    (i_clk),
                .i_reset  (i_reset),
                .i_rs     (i_op.rs),
                .i_rt     (i_op.rt),
                .i_we     (i_wb.valid && i_wb.write_reg),
                .i_wd_rd  (i_wb.rd),
                .i_wd     (i_wb.wb_data),
                .o_rs_val (rs_val),
                .o_rt_val (rt_val)
        );

        assign op_live = i_op_valid && i_op.valid;

        always_comb begin
                id_ex_d.valid     = op_live;
                id_ex_d.alu_op    = i_op.alu_op;
                id_ex_d.use_imm   = i_op.use_imm;
                id_ex_d.mem_read  = op_live && i_op.mem_read;
                id_ex_d.mem_write = op_live && i_op.mem_write;
                id_ex_d.write_reg = op_live && !i_op.mem_write && (i_op.rd != '0); // r0 never forwarded
                id_ex_d.rd        = i_op.rd;
                id_ex_d.rs        = i_op.rs;
                id_ex_d.rt        = i_op.rt;
                id_ex_d.rs_val    = rs_val;
                id_ex_d.rt_val    = rt_val;
                id_ex_d.imm       = {{(`PIPE_DATA_BITS-`PIPE_IMM_BITS){i_op.imm[`PIPE_IMM_BITS-1]}},
                                     i_op.imm};       // Sign extend
        end

        // ID/EX register, only control bits cleared
        always_ff @(posedge i_clk) begin
                id_ex_q <= id_ex_d;
                if (i_reset) begin
                        id_ex_q.valid     <= 1'b0;
                        id_ex_q.mem_read  <= 1'b0;
                        id_ex_q.mem_write <= 1'b0;
                        id_ex_q.write_reg <= 1'b0;
                end
        end

        assign o_id_ex = id_ex_q;

endmodule

//--- hdl/execute_stage.sv
module execute_stage import pipe_pkg::*; (
        input  logic    i_clk,
        input  logic    i_reset,
        input  id_ex_t  i_id_ex,
        input  mem_wb_t i_mem_wb,       // Result from two ops back
        output ex_mem_t o_ex_mem
);

        fwd_sel_t   fwd_a;
        fwd_sel_t   fwd_b;
        store_sel_t fwd_store;
        word_t      opnd_a;
        word_t      opnd_b_fwd;         // B after forwarding and before the immediate
        word_t      opnd_b;
        word_t      alu_result;
        word_t      store_data;
        ex_mem_t    ex_mem_d;
        ex_mem_t    ex_mem_q;

        forwarding_unit u_fwd (
                .i_ex_mem_rd        (ex_mem_q.rd),
                .i_mem_wb_rd        (i_mem_wb.rd),
                .i_rs               (i_id_ex.rs),
                .i_rt               (i_id_ex.rt),
                .i_ex_mem_write     (i_id_ex.mem_write),
                .i_mem_write_reg    (ex_mem_q.write_reg),
                .i_wb_write_reg     (i_mem_wb.write_reg),
                .o_forwarding_a     (fwd_a),
                .o_forwarding_b     (fwd_b),
                .o_forwarding_store (fwd_store)
        );

        // ########################################
        // Operand muxes
        // ########################################
        always_comb begin
                case (fwd_a)
                        FWD_MEM: opnd_a = ex_mem_q.alu_result;
                        FWD_WB:  opnd_a = i_mem_wb.wb_data;
                        default: opnd_a = i_id_ex.rs_val;
                endcase
                case (fwd_b)
                        FWD_MEM: opnd_b_fwd = ex_mem_q.alu_result;
                        FWD_WB:  opnd_b_fwd = i_mem_wb.wb_data;
                        default: opnd_b_fwd = i_id_ex.rt_val;
                endcase
        end

        assign opnd_b = i_id_ex.use_imm ? i_id_ex.imm : opnd_b_fwd; // addi, lw, sw

        // ALU also forms the lw and sw addresses as add
        always_comb begin
                case (i_id_ex.alu_op)
                        ALU_SUB: alu_result = opnd_a - opnd_b;
                        ALU_AND: alu_result = opnd_a & opnd_b;
                        ALU_OR:  alu_result = opnd_a | opnd_b;
                        default: alu_result = opnd_a + opnd_b;
                endcase
        end

        // Store data mux
        always_comb begin
                case (fwd_store)
                        ST_MEM:  store_data = ex_mem_q.alu_result;
                        ST_WB:   store_data = i_mem_wb.wb_data;
                        default: store_data = opnd_b_fwd;       // Plain rt
                endcase
        end

        assign ex_mem_d = '{valid:      i_id_ex.valid,
                            mem_read:   i_id_ex.mem_read,
                            mem_write:  i_id_ex.mem_write,
                            write_reg:  i_id_ex.write_reg,
                            rd:         i_id_ex.rd,
                            alu_result: alu_result,
                            store_data: store_data};

        always_ff @(posedge i_clk) begin
                ex_mem_q <= ex_mem_d;
                if (i_reset) begin
                        ex_mem_q.valid     <= 1'b0;
                        ex_mem_q.mem_read  <= 1'b0;
                        ex_mem_q.mem_write <= 1'b0;     // No store out of reset
                        ex_mem_q.write_reg <= 1'b0;
                end
        end

        assign o_ex_mem = ex_mem_q;

endmodule

//--- hdl/memory_stage.sv
`include "pipe_macros.svh"

module memory_stage import pipe_pkg::*; (
        input  logic    i_clk,
        input  logic    i_reset,
        input  ex_mem_t i_ex_mem,
        output mem_wb_t o_mem_wb
);

        localparam int ADDR_BITS = $clog2(`PIPE_MEM_WORDS);

        word_t                 mem_q [`PIPE_MEM_WORDS];
        logic [ADDR_BITS-1:0]  addr;            // Word index, wraps at depth
        word_t                 load_data;
        mem_wb_t               mem_wb_d;
        mem_wb_t               mem_wb_q;

        assign addr      = i_ex_mem.alu_result[ADDR_BITS-1:0];
        assign load_data = mem_q[addr];         // Async read

        // ########################################
        // Data memory
        // ########################################
        always_ff @(posedge i_clk) begin
                if (i_reset) begin
                        for (int i = 0; i < `PIPE_MEM_WORDS; i++) begin
                                mem_q[i] <= '0;
                        end
                end else if (i_ex_mem.valid && i_ex_mem.mem_write) begin
                        mem_q[addr] <= i_ex_mem.store_data;     // sw
                end
        end

        always_comb begin
                mem_wb_d.valid     = i_ex_mem.valid;
                mem_wb_d.write_reg = i_ex_mem.write_reg;
                mem_wb_d.rd        = i_ex_mem.rd;
                mem_wb_d.wb_data   = i_ex_mem.mem_read ? load_data : i_ex_mem.alu_result;
        end

        // MEM/WB register
        always_ff @(posedge i_clk) begin
                mem_wb_q <= mem_wb_d;
                if (i_reset) begin
                        mem_wb_q.valid     <= 1'b0;
                        mem_wb_q.write_reg <= 1'b0;
                end
        end

        assign o_mem_wb = mem_wb_q;

endmodule

//--- hdl/pipeline_core.sv
module pipeline_core import pipe_pkg::*; (
        input  logic     i_clk,
        input  logic     i_reset,
        input  logic     i_op_valid,    // One decoded op per strobe
        input  op_t      i_op,
        output logic     o_wb_valid,
        output reg_idx_t o_wb_rd,
        output word_t    o_wb_data
);

        id_ex_t  id_ex;
        ex_mem_t ex_mem;
        mem_wb_t mem_wb;                // Also the write back loop

        // ########################################
        // Stages
        // ########################################

        decode_stage u_decode (
                .i_clk      (i_clk),
                .i_reset    (i_reset),
                .i_op_valid (i_op_valid),
                .i_op       (i_op),
                .i_wb       (mem_wb),           // Register file write port
                .o_id_ex    (id_ex)
        );

        execute_stage u_execute (
                .i_clk      (i_clk),
                .i_reset    (i_reset),
                .i_id_ex    (id_ex),
                .i_mem_wb   (mem_wb),           // MEM/WB forwarding
                .o_ex_mem   (ex_mem)
        );

        memory_stage u_memory (
                .i_clk      (i_clk),
                .i_reset    (i_reset),
                .i_ex_mem   (ex_mem),
                .o_mem_wb   (mem_wb)
        );

        // Write back ports, three cycles after the strobe
        assign o_wb_valid = mem_wb.valid && mem_wb.write_reg;
        assign o_wb_rd    = mem_wb.rd;
        assign o_wb_data  = mem_wb.wb_data;

endmodule

//--- test/wb_checker.sv
module wb_checker import pipe_pkg::*; (
        input  logic     i_clk,
        input  logic     i_reset,
        input  logic     i_op_valid,    // Watched at the DUT inputs
        input  op_t      i_op,
        input  logic     i_wb_valid,
        input  reg_idx_t i_wb_rd,
        input  word_t    i_wb_data,
        output int       o_mismatches,
        output int       o_failures,
        output int       o_pending,
        output int       o_checked
);

        reg_idx_t exp_rd [$];                   // Expected write-backs in order
        word_t    exp_data [$];
        int       strobe_edge [$];              // Edge at which each writer was taken
        int       edge_cnt = 0;
        int       mismatches = 0;
        int       failures = 0;
        int       pending = 0;
        int       checked = 0;

        assign o_mismatches = mismatches;
        assign o_failures   = failures;
        assign o_pending    = pending;
        assign o_checked    = checked;

        // Only strobed reg ALU, addi and lw ops with a nonzero rd write back
        task automatic read_expected();
                int    fd;
                int    strobe, kind, alu, rd, rs, rt, imm, wb_value;
                string line;
                fd = $fopen("test/testdata_ops.txt", "r");
                if (fd == 0) begin
                        $display("checker could not open test/testdata_ops.txt");
                        failures++;
                        return;
                end
                while ($fgets(line, fd) != 0) begin
                        if (line.len() > 1 && line.getc(0) != "#" &&
                            $sscanf(line, "%d %d %d %d %d %d %h %h",
                                    strobe, kind, alu, rd, rs, rt, imm, wb_value) == 8 &&
                            strobe != 0 && kind >= 1 && kind <= 3 && rd != 0) begin
                                exp_rd.push_back(reg_idx_t'(rd));
                                exp_data.push_back(word_t'(wb_value));
                        end
                end
                $fclose(fd);
                pending = exp_rd.size();
        endtask

        initial read_expected();

        task automatic check_write_back();
                int lag;
                if (exp_rd.size() == 0) begin
                        $display("unexpected write-back to r%0d at time %0t", i_wb_rd, $time);
                        failures++;
                        return;
                end
                if (i_wb_rd !== exp_rd[0]) begin
                        $display("mismatch at %0t: o_wb_rd expected %0d, got %0d",
                                 $time, exp_rd[0], i_wb_rd);
                        mismatches++;
                end
                if (i_wb_data !== exp_data[0]) begin
                        $display("mismatch at %0t: o_wb_data expected %h, got %h",
                                 $time, exp_data[0], i_wb_data);
                        mismatches++;
                end
                if (strobe_edge.size() == 0) begin
                        $display("write-back to r%0d at time %0t has no strobed op behind it",
                                 i_wb_rd, $time);
                        failures++;
                end else begin
                        lag = edge_cnt - strobe_edge.pop_front();
                        if (lag != 3) begin
                                $display("write-back to r%0d came %0d cycles after strobe",
                                         i_wb_rd, lag);
                                failures++;
                        end
                end
                void'(exp_rd.pop_front());
                void'(exp_data.pop_front());
                checked++;
                pending = exp_rd.size();
        endtask

        // ########################################
        // Sampling at each rising edge
        // ########################################
        always @(posedge i_clk) begin
                edge_cnt++;
                if (i_reset) begin
                        if (i_wb_valid === 1'b1) begin  // Nothing may leave during reset
                                $display("write-back seen during reset at time %0t", $time);
                                failures++;
                        end
                end else begin
                        if (i_op_valid && i_op.valid && !i_op.mem_write && i_op.rd != '0) begin
                                strobe_edge.push_back(edge_cnt);
                        end
                        if (i_wb_valid) begin
                                check_write_back();
                        end
                end
        end

endmodule

//--- test/tb_pipeline_core.sv
module tb_pipeline_core import pipe_pkg::*; ();

        logic     i_clk;
        logic     i_reset;
        logic     i_op_valid;
        op_t      i_op;
        logic     o_wb_valid;
        reg_idx_t o_wb_rd;
        word_t    o_wb_data;

        int       mismatches;                   // From the checker
        int       failures;
        int       pending;                      // Write-backs still owed
        int       checked;
        int       load_errors = 0;
        int       cycle_limit = 1000;           // Set from the line count once loaded
        int       cycles = 0;
        logic     strobes [$];
        op_t      ops [$];

        pipeline_core uut (
                .i_clk      (i_clk),
                .i_reset    (i_reset),
                .i_op_valid (i_op_valid),
                .i_op       (i_op),
                .o_wb_valid (o_wb_valid),
                .o_wb_rd    (o_wb_rd),
                .o_wb_data  (o_wb_data)
        );

        wb_checker u_check (
                .i_clk        (i_clk),
                .i_reset      (i_reset),
                .i_op_valid   (i_op_valid),
                .i_op         (i_op),
                .i_wb_valid   (o_wb_valid),
                .i_wb_rd      (o_wb_rd),
                .i_wb_data    (o_wb_data),
                .o_mismatches (mismatches),
                .o_failures   (failures),
                .o_pending    (pending),
                .o_checked    (checked)
        );

        initial begin
                i_clk = 1'b0;
                forever #10 i_clk = ~i_clk;     // Period 20
        end

        // Kind codes 0 nop, 1 reg ALU, 2 addi, 3 lw, 4 sw
        function automatic op_t build_op(int kind, int alu, int rd, int rs, int rt, int imm);
                op_t op;
                op           = '0;
                op.valid     = (kind != 0);     // nop goes in as an invalid op
                op.alu_op    = (kind == 1) ? alu_op_t'(alu[1:0]) : ALU_ADD;
                op.use_imm   = (kind >= 2);
                op.mem_read  = (kind == 3);
                op.mem_write = (kind == 4);
                op.rd        = reg_idx_t'(rd);
                op.rs        = reg_idx_t'(rs);
                op.rt        = reg_idx_t'(rt);
                op.imm       = imm_t'(imm);
                return op;
        endfunction

        task automatic load_ops();
                int    fd;
                int    strobe, kind, alu, rd, rs, rt, imm, wb_value;
                string line;
                fd = $fopen("test/testdata_ops.txt", "r");
                if (fd == 0) begin
                        $display("could not open test/testdata_ops.txt");
                        load_errors++;
                        return;
                end
                while ($fgets(line, fd) != 0) begin
                        if (line.len() > 1 && line.getc(0) != "#" &&
                            $sscanf(line, "%d %d %d %d %d %d %h %h",
                                    strobe, kind, alu, rd, rs, rt, imm, wb_value) == 8) begin
                                strobes.push_back(strobe != 0);
                                ops.push_back(build_op(kind, alu, rd, rs, rt, imm));
                        end
                end
                $fclose(fd);
        endtask

        // ########################################
        // Stimulus
        // ########################################
        initial begin
                i_reset    <= 1'b1;
                i_op_valid <= 1'b0;
                i_op       <= '0;
                load_ops();
                cycle_limit = ops.size() + 20;
                if (ops.size() == 0) begin
                        $display("no operations found in the test data");
                        load_errors++;
                end
                repeat (5) @(posedge i_clk);
                i_reset <= 1'b0;
                foreach (ops[k]) begin
                        @(posedge i_clk);
                        i_op_valid <= strobes[k];       // Low strobe is a bubble
                        i_op       <= ops[k];
                end
                @(posedge i_clk);
                i_op_valid <= 1'b0;
                i_op       <= '0;
                wait (pending == 0);
                repeat (4) @(posedge i_clk);            // Room for stray write-backs
                @(negedge i_clk);
                $display("errors: %0d mismatches, %0d failures, %0d load errors, %0d checked",
                         mismatches, failures, load_errors, checked);
                if (mismatches + failures + load_errors == 0) begin
                        $display("Simulation finished: PASS");
                end else begin
                        $display("Simulation finished: FAIL");
                end
                $finish;
        end

        // Watchdog counting cycles after reset
        always @(posedge i_clk) begin
                if (!i_reset) begin
                        cycles <= cycles + 1;
                        if (cycles >= cycle_limit) begin
                                $display("timeout after %0d cycles with %0d write-backs missing",
                                         cycles, pending);
                                $display("Simulation finished: FAIL");
                                $finish;
                        end
                end
        end

endmodule

//--- test/testdata_ops.txt
# strobe kind(0 nop 1 alu 2 addi 3 lw 4 sw) alu(0 add 1 sub 2 and 3 or) rd rs rt
# then imm(hex) and expected write-back(hex, ignored when nothing is written)
1 2 0 1 0 0 0005 00000005
1 2 0 2 0 0 0003 00000003
1 2 0 3 0 0 fffe fffffffe
1 1 0 4 1 2 0000 00000008
1 1 1 5 4 1 0000 00000003
1 1 2 6 3 5 0000 00000002
1 1 3 7 6 2 0000 00000003
1 1 0 8 1 7 0000 00000008
1 2 0 9 0 0 0064 00000064
1 2 0 9 0 0 00c8 000000c8
1 1 0 10 9 1 0000 000000cd
1 1 1 11 8 9 0000 ffffff40
1 2 0 12 0 0 0abc 00000abc
1 4 0 0 0 12 0010 00000000
1 2 0 13 0 0 0123 00000123
1 0 0 0 0 0 0000 00000000
1 4 0 0 1 13 0014 00000000
1 0 0 0 0 0 0000 00000000
1 3 0 14 0 0 0010 00000abc
1 3 0 15 0 0 0019 00000123
1 2 0 0 0 0 0077 00000000
1 1 0 16 0 1 0000 00000005
0 2 0 17 0 0 0055 00000000
0 2 0 17 0 0 0066 00000000
1 3 0 18 0 0 0010 00000abc
1 0 0 0 0 0 0000 00000000
1 1 0 19 18 2 0000 00000abf
1 1 3 20 17 0 0000 00000000

//--- vlog.f
+incdir+hdl
hdl/pipe_pkg.sv
hdl/register_file.sv
hdl/forwarding_unit.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/pipeline_core.sv
test/wb_checker.sv
test/tb_pipeline_core.sv

//--- Makefile
# Verilator build and run for the pipeline testbench

VERILATOR  ?= verilator
TOP        ?= tb_pipeline_core
FILELIST   ?= vlog.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary -j 0
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Simulation finished: PASS" $(LOG) || (echo "run failed, see $(LOG)" && exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
